/* design/stock_pkg.sv */
`default_nettype none

package stock_pkg;

    // ==============================
    // widths and limits
    // ==============================
    localparam int INDEX_W     = 12;
    localparam int ADDR_W      = 17;
    localparam int DATA_NO_W   = 8;
    localparam int RECORD_W    = 64;

    // calc start to registered risk bit
    localparam int CALC_CYCLES = 4;

    // formula D limit
    localparam int HIGH_INDEX  = 2047;

    // ==============================
    // record layout
    // ==============================
    // lsb of each field in the 64-bit record
    localparam int REC_A_LSB     = 52;
    localparam int REC_B_LSB     = 40;
    localparam int REC_MONTH_LSB = 32;
    localparam int REC_C_LSB     = 20;
    localparam int REC_D_LSB     = 8;
    localparam int REC_DAY_LSB   = 0;

    // ==============================
    // types
    // ==============================
    typedef enum logic {
        index_check      = 1'b0,
        check_valid_date = 1'b1
    } action_t;

    typedef enum logic [2:0] {
        formula_a = 3'd0,
        formula_b = 3'd1,
        formula_c = 3'd2,
        formula_d = 3'd3,
        formula_e = 3'd4
    } formula_t;

    typedef enum logic [1:0] {
        insensitive = 2'b00,
        normal      = 2'b01,
        sensitive   = 2'b11
    } mode_t;

    // 2'b10 is not used
    typedef enum logic [1:0] {
        no_warn   = 2'b00,
        date_warn = 2'b01,
        risk_warn = 2'b11
    } warn_t;

    typedef enum logic [1:0] {
        idle    = 2'd0,
        collect = 2'd1,
        calc    = 2'd2,
        answer  = 2'd3
    } op_state_t;

    typedef logic [3:0] month_t;
    typedef logic [4:0] day_t;

endpackage

`default_nettype wire

/* design/op_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module op_fsm
    import stock_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          sel_action_valid,
    input  wire action_t action_q,
    input  wire          indices_full,
    input  wire          record_ready,
    input  wire          calc_done,
    output logic         calc_en,
    output logic         op_done
);

    op_state_t state;
    op_state_t next_state;
    logic      inputs_ready;

    // date check needs only the record, index check also the four indices
    assign inputs_ready = record_ready &&
                          ((action_q == check_valid_date) || indices_full);

    // ==============================
    // next state
    // ==============================
    always_comb begin
        case (state)
            idle:    next_state = sel_action_valid ? collect : idle;
            collect: next_state = inputs_ready ? calc : collect;
            calc:    next_state = calc_done ? answer : calc;
            answer:  next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    assign calc_en = (state == calc);
    assign op_done = (state == answer);

endmodule

`default_nettype wire

/* design/calc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_counter
    import stock_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  calc_en,
    output logic calc_done
);

    localparam int CNT_W = $clog2(CALC_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    // holds at the last count until calc ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!calc_en) begin
            cnt <= '0;
        end else if (!calc_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    // high in the CALC_CYCLES-th cycle of calc
    assign calc_done = calc_en && (cnt == CNT_W'(CALC_CYCLES - 1));

endmodule

`default_nettype wire

/* design/input_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module input_capture
    import stock_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      sel_action_valid,
    input  wire action_t             action,
    input  wire                      formula_valid,
    input  wire formula_t            formula,
    input  wire                      mode_valid,
    input  wire mode_t               mode,
    input  wire                      date_valid,
    input  wire month_t              month,
    input  wire day_t                day,
    input  wire                      index_valid,
    input  wire logic [INDEX_W-1:0]  index,
    input  wire                      op_done,
    output action_t                  action_q,
    output formula_t                 formula_q,
    output mode_t                    mode_q,
    output month_t                   month_q,
    output day_t                     day_q,
    output logic [INDEX_W-1:0]       today_a,
    output logic [INDEX_W-1:0]       today_b,
    output logic [INDEX_W-1:0]       today_c,
    output logic [INDEX_W-1:0]       today_d,
    output logic                     indices_full
);

    logic [2:0] index_cnt;

    // ==============================
    // operation fields
    // ==============================
    always_ff @(posedge clk) begin
        if (sel_action_valid) begin
            action_q <= action;
        end
        if (formula_valid) begin
            formula_q <= formula;
        end
        if (mode_valid) begin
            mode_q <= mode;
        end
        if (date_valid) begin
            month_q <= month;
            day_q   <= day;
        end
    end

    // indices arrive A first, so A ends at the far end of the chain
    always_ff @(posedge clk) begin
        if (index_valid) begin
            today_d <= index;
            today_c <= today_d;
            today_b <= today_c;
            today_a <= today_b;
        end
    end

    // ==============================
    // index count
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_cnt <= '0;
        end else if (op_done) begin
            index_cnt <= '0;
        end else if (index_valid && !indices_full) begin
            index_cnt <= index_cnt + 1'b1;
        end
    end

    assign indices_full = (index_cnt == 3'd4);

endmodule

`default_nettype wire

/* design/record_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module record_fetch
    import stock_pkg::*;
#(
    parameter int BASE_ADDR = 65536
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        data_no_valid,
    input  wire logic [DATA_NO_W-1:0]  data_no,
    input  wire                        mem_ack,
    input  wire logic [RECORD_W-1:0]   mem_data,
    input  wire                        op_done,
    output logic                       mem_rd,
    output logic [ADDR_W-1:0]          mem_addr,
    output logic                       record_ready,
    output logic [INDEX_W-1:0]         rec_a,
    output logic [INDEX_W-1:0]         rec_b,
    output logic [INDEX_W-1:0]         rec_c,
    output logic [INDEX_W-1:0]         rec_d,
    output month_t                     rec_month,
    output day_t                       rec_day
);

    logic [RECORD_W-1:0] rec_buf;

    // ==============================
    // read request
    // ==============================
    // one-cycle strobe right after the data number arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd <= 1'b0;
        end else begin
            mem_rd <= data_no_valid;
        end
    end

    // records are 8 bytes apart
    always_ff @(posedge clk) begin
        if (data_no_valid) begin
            mem_addr <= ADDR_W'(BASE_ADDR) + ADDR_W'({data_no, 3'b000});
        end
    end

    // ==============================
    // read data
    // ==============================
    always_ff @(posedge clk) begin
        if (mem_ack) begin
            rec_buf <= mem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            record_ready <= 1'b0;
        end else if (mem_ack) begin
            record_ready <= 1'b1;
        end else if (op_done) begin
            record_ready <= 1'b0;
        end
    end

    // month and day fields are 8 bits wide, only the low bits are meaningful
    assign rec_a     = rec_buf[REC_A_LSB +: INDEX_W];
    assign rec_b     = rec_buf[REC_B_LSB +: INDEX_W];
    assign rec_c     = rec_buf[REC_C_LSB +: INDEX_W];
    assign rec_d     = rec_buf[REC_D_LSB +: INDEX_W];
    assign rec_month = rec_buf[REC_MONTH_LSB +: $bits(month_t)];
    assign rec_day   = rec_buf[REC_DAY_LSB +: $bits(day_t)];

endmodule

`default_nettype wire

/* design/formula_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module formula_pipe
    import stock_pkg::*;
(
    input  wire                       clk,
    input  wire formula_t             formula_q,
    input  wire logic [INDEX_W-1:0]   rec_a,
    input  wire logic [INDEX_W-1:0]   rec_b,
    input  wire logic [INDEX_W-1:0]   rec_c,
    input  wire logic [INDEX_W-1:0]   rec_d,
    input  wire logic [INDEX_W-1:0]   today_a,
    input  wire logic [INDEX_W-1:0]   today_b,
    input  wire logic [INDEX_W-1:0]   today_c,
    input  wire logic [INDEX_W-1:0]   today_d,
    output logic [INDEX_W-1:0]        formula_result
);

    logic [INDEX_W-1:0] rec_v   [4];
    logic [INDEX_W-1:0] today_v [4];

    // stage 1
    logic [INDEX_W-1:0]        s1_max_ab;
    logic [INDEX_W-1:0]        s1_min_ab;
    logic [INDEX_W-1:0]        s1_max_cd;
    logic [INDEX_W-1:0]        s1_min_cd;
    logic [INDEX_W+1:0]        s1_sum;
    logic signed [INDEX_W:0]   s1_diff [4];
    logic [3:0]                s1_high;
    logic [3:0]                s1_fell;

    // stage 2
    logic [INDEX_W-1:0]        s2_max;
    logic [INDEX_W-1:0]        s2_min;
    logic [INDEX_W-1:0]        s2_avg;
    logic [2:0]                s2_high_cnt;
    logic [2:0]                s2_fell_cnt;

    assign rec_v   = '{rec_a, rec_b, rec_c, rec_d};
    assign today_v = '{today_a, today_b, today_c, today_d};

    // ==============================
    // stage 1: compare, sum, diff
    // ==============================
    always_ff @(posedge clk) begin
        s1_max_ab <= (rec_a > rec_b) ? rec_a : rec_b;
        s1_min_ab <= (rec_a > rec_b) ? rec_b : rec_a;
        s1_max_cd <= (rec_c > rec_d) ? rec_c : rec_d;
        s1_min_cd <= (rec_c > rec_d) ? rec_d : rec_c;
        s1_sum    <= (INDEX_W+2)'(rec_a) + (INDEX_W+2)'(rec_b)
                   + (INDEX_W+2)'(rec_c) + (INDEX_W+2)'(rec_d);
        for (int i = 0; i < 4; i++) begin
            s1_diff[i] <= $signed({1'b0, today_v[i]}) - $signed({1'b0, rec_v[i]});
            s1_high[i] <= (rec_v[i] >= INDEX_W'(HIGH_INDEX));
        end
    end

    // negative diff means the index fell since the record
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            s1_fell[i] = s1_diff[i][INDEX_W];
        end
    end

    // ==============================
    // stage 2: reduce
    // ==============================
    always_ff @(posedge clk) begin
        s2_max      <= (s1_max_ab > s1_max_cd) ? s1_max_ab : s1_max_cd;
        s2_min      <= (s1_min_ab < s1_min_cd) ? s1_min_ab : s1_min_cd;
        s2_avg      <= s1_sum[INDEX_W+1:2];
        s2_high_cnt <= 3'($countones(s1_high));
        s2_fell_cnt <= 3'($countones(s1_fell));
    end

    // ==============================
    // stage 3: select
    // ==============================
    always_ff @(posedge clk) begin
        case (formula_q)
            formula_a: formula_result <= s2_avg;
            formula_b: formula_result <= s2_max - s2_min;
            formula_c: formula_result <= s2_min;
            formula_d: formula_result <= INDEX_W'(s2_high_cnt);
            formula_e: formula_result <= INDEX_W'(s2_fell_cnt);
            default:   formula_result <= '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/risk_judge.sv */
`timescale 1ns/1ps
`default_nettype none

module risk_judge
    import stock_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire formula_t            formula_q,
    input  wire mode_t               mode_q,
    input  wire action_t             action_q,
    input  wire month_t              month_q,
    input  wire day_t                day_q,
    input  wire month_t              rec_month,
    input  wire day_t                rec_day,
    input  wire logic [INDEX_W-1:0]  formula_result,
    input  wire                      op_done,
    output logic                     out_valid,
    output warn_t                    warn_msg,
    output logic                     complete
);

    logic [INDEX_W-1:0] threshold;
    logic               risk_q;
    logic               date_bad;
    warn_t              verdict;

    // ==============================
    // threshold table
    // ==============================
    always_comb begin
        case (formula_q)
            formula_a, formula_c: begin
                case (mode_q)
                    insensitive: threshold = 12'd2047;
                    normal:      threshold = 12'd1023;
                    default:     threshold = 12'd511;
                endcase
            end
            formula_b: begin
                case (mode_q)
                    insensitive: threshold = 12'd800;
                    normal:      threshold = 12'd400;
                    default:     threshold = 12'd200;
                endcase
            end
            formula_d, formula_e: begin
                case (mode_q)
                    insensitive: threshold = 12'd3;
                    normal:      threshold = 12'd2;
                    default:     threshold = 12'd1;
                endcase
            end
            // unused codes never flag a risk
            default: threshold = '1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            risk_q <= 1'b0;
        end else begin
            risk_q <= (formula_result >= threshold);
        end
    end

    // today earlier than the stored date
    assign date_bad = (month_q < rec_month) ||
                      ((month_q == rec_month) && (day_q < rec_day));

    // date outranks risk
    always_comb begin
        if (date_bad) begin
            verdict = date_warn;
        end else if ((action_q == index_check) && risk_q) begin
            verdict = risk_warn;
        end else begin
            verdict = no_warn;
        end
    end

    // ==============================
    // output registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            warn_msg  <= no_warn;
            complete  <= 1'b0;
        end else begin
            out_valid <= op_done;
            warn_msg  <= op_done ? verdict : no_warn;
            complete  <= op_done && (verdict == no_warn);
        end
    end

endmodule

`default_nettype wire

/* design/stock_check_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stock_check_top
    import stock_pkg::*;
#(
    parameter int BASE_ADDR = 65536
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sel_action_valid,
    input  wire action_t               action,
    input  wire                        formula_valid,
    input  wire formula_t              formula,
    input  wire                        mode_valid,
    input  wire mode_t                 mode,
    input  wire                        date_valid,
    input  wire month_t                month,
    input  wire day_t                  day,
    input  wire                        data_no_valid,
    input  wire logic [DATA_NO_W-1:0]  data_no,
    input  wire                        index_valid,
    input  wire logic [INDEX_W-1:0]    index,
    output logic                       mem_rd,
    output logic [ADDR_W-1:0]          mem_addr,
    input  wire                        mem_ack,
    input  wire logic [RECORD_W-1:0]   mem_data,
    output logic                       out_valid,
    output warn_t                      warn_msg,
    output logic                       complete
);

    action_t            action_q;
    formula_t           formula_q;
    mode_t              mode_q;
    month_t             month_q;
    day_t               day_q;
    month_t             rec_month;
    day_t               rec_day;
    logic [INDEX_W-1:0] today_a;
    logic [INDEX_W-1:0] today_b;
    logic [INDEX_W-1:0] today_c;
    logic [INDEX_W-1:0] today_d;
    logic [INDEX_W-1:0] rec_a;
    logic [INDEX_W-1:0] rec_b;
    logic [INDEX_W-1:0] rec_c;
    logic [INDEX_W-1:0] rec_d;
    logic [INDEX_W-1:0] formula_result;
    logic               indices_full;
    logic               record_ready;
    logic               calc_en;
    logic               calc_done;
    logic               op_done;

    // ==============================
    // control
    // ==============================
    op_fsm u_op_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .sel_action_valid (sel_action_valid),
        .action_q         (action_q),
        .indices_full     (indices_full),
        .record_ready     (record_ready),
        .calc_done        (calc_done),
        .calc_en          (calc_en),
        .op_done          (op_done)
    );

    calc_counter u_calc_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .calc_en   (calc_en),
        .calc_done (calc_done)
    );

    // ==============================
    // inputs and memory
    // ==============================
    input_capture u_input_capture (
        .clk              (clk),
        .rst_n            (rst_n),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .formula_valid    (formula_valid),
        .formula          (formula),
        .mode_valid       (mode_valid),
        .mode             (mode),
        .date_valid       (date_valid),
        .month            (month),
        .day              (day),
        .index_valid      (index_valid),
        .index            (index),
        .op_done          (op_done),
        .action_q         (action_q),
        .formula_q        (formula_q),
        .mode_q           (mode_q),
        .month_q          (month_q),
        .day_q            (day_q),
        .today_a          (today_a),
        .today_b          (today_b),
        .today_c          (today_c),
        .today_d          (today_d),
        .indices_full     (indices_full)
    );

    record_fetch #(
        .BASE_ADDR (BASE_ADDR)
    ) u_record_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_no_valid (data_no_valid),
        .data_no       (data_no),
        .mem_ack       (mem_ack),
        .mem_data      (mem_data),
        .op_done       (op_done),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr),
        .record_ready  (record_ready),
        .rec_a         (rec_a),
        .rec_b         (rec_b),
        .rec_c         (rec_c),
        .rec_d         (rec_d),
        .rec_month     (rec_month),
        .rec_day       (rec_day)
    );

    // ==============================
    // evaluation
    // ==============================
    formula_pipe u_formula_pipe (
        .clk            (clk),
        .formula_q      (formula_q),
        .rec_a          (rec_a),
        .rec_b          (rec_b),
        .rec_c          (rec_c),
        .rec_d          (rec_d),
        .today_a        (today_a),
        .today_b        (today_b),
        .today_c        (today_c),
        .today_d        (today_d),
        .formula_result (formula_result)
    );

    risk_judge u_risk_judge (
        .clk            (clk),
        .rst_n          (rst_n),
        .formula_q      (formula_q),
        .mode_q         (mode_q),
        .action_q       (action_q),
        .month_q        (month_q),
        .day_q          (day_q),
        .rec_month      (rec_month),
        .rec_day        (rec_day),
        .formula_result (formula_result),
        .op_done        (op_done),
        .out_valid      (out_valid),
        .warn_msg       (warn_msg),
        .complete       (complete)
    );

endmodule

`default_nettype wire

/* testbench/tb_stock_check.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stock_check
    import stock_pkg::*;
();

    localparam int BASE_ADDR     = 65536;
    localparam int MAX_PAT       = 64;
    localparam int CYCLES_PER_OP = 60;

    logic                  clk;
    logic                  rst_n;
    logic                  sel_action_valid;
    action_t               action;
    logic                  formula_valid;
    formula_t              formula;
    logic                  mode_valid;
    mode_t                 mode;
    logic                  date_valid;
    month_t                month;
    day_t                  day;
    logic                  data_no_valid;
    logic [DATA_NO_W-1:0]  data_no;
    logic                  index_valid;
    logic [INDEX_W-1:0]    index;
    logic                  mem_rd;
    logic [ADDR_W-1:0]     mem_addr;
    logic                  mem_ack;
    logic [RECORD_W-1:0]   mem_data;
    logic                  out_valid;
    warn_t                 warn_msg;
    logic                  complete;

    // one pattern table entry per operation
    int                    pat_action   [MAX_PAT];
    int                    pat_formula  [MAX_PAT];
    int                    pat_mode     [MAX_PAT];
    int                    pat_month    [MAX_PAT];
    int                    pat_day      [MAX_PAT];
    int                    pat_data_no  [MAX_PAT];
    int                    pat_today    [MAX_PAT][4];
    logic [RECORD_W-1:0]   pat_record   [MAX_PAT];
    int                    pat_warn     [MAX_PAT];
    int                    pat_complete [MAX_PAT];
    int                    n_pat;

    logic [ADDR_W-1:0]     exp_addr;
    logic [RECORD_W-1:0]   cur_record;
    int                    reads_seen;
    int                    answers_seen;
    logic [15:0]           lfsr;
    int                    cycles;

    stock_check_top #(
        .BASE_ADDR (BASE_ADDR)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .formula_valid    (formula_valid),
        .formula          (formula),
        .mode_valid       (mode_valid),
        .mode             (mode),
        .date_valid       (date_valid),
        .month            (month),
        .day              (day),
        .data_no_valid    (data_no_valid),
        .data_no          (data_no),
        .index_valid      (index_valid),
        .index            (index),
        .mem_rd           (mem_rd),
        .mem_addr         (mem_addr),
        .mem_ack          (mem_ack),
        .mem_data         (mem_data),
        .out_valid        (out_valid),
        .warn_msg         (warn_msg),
        .complete         (complete)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // error reporting and compares
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_warn(input warn_t got, input warn_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s, got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_complete(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s, got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s, got %0d expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("Fail at %0t ns: %s, got %0d expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // ==============================
    // memory delay source
    // ==============================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // two bits per draw give 1 to 4 cycles
    function automatic int draw_delay();
        int bits;
        bits = 0;
        for (int i = 0; i < 2; i++) begin
            bits = (bits << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return bits + 1;
    endfunction

    task automatic load_patterns();
        int                  fd;
        int                  rc;
        string               line;
        int                  act, frm, md, mon, dy, dno, t0, t1, t2, t3, wrn, cpl;
        logic [RECORD_W-1:0] rec;
        fd = $fopen("testbench/stock_check_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open testbench/stock_check_patterns.txt");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            rc = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %h %d %d",
                         act, frm, md, mon, dy, dno, t0, t1, t2, t3, rec, wrn, cpl);
            if (rc != 13 || n_pat >= MAX_PAT) begin
                abort_run($sformatf("Cannot use this line of the patterns file: %s", line));
            end
            pat_action[n_pat]   = act;
            pat_formula[n_pat]  = frm;
            pat_mode[n_pat]     = md;
            pat_month[n_pat]    = mon;
            pat_day[n_pat]      = dy;
            pat_data_no[n_pat]  = dno;
            pat_today[n_pat][0] = t0;
            pat_today[n_pat][1] = t1;
            pat_today[n_pat][2] = t2;
            pat_today[n_pat][3] = t3;
            pat_record[n_pat]   = rec;
            pat_warn[n_pat]     = wrn;
            pat_complete[n_pat] = cpl;
            n_pat++;
        end
        $fclose(fd);
        if (n_pat == 0) begin
            abort_run("The patterns file holds no operations");
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    task automatic apply_op(input int k);
        @(posedge clk);
        exp_addr         = ADDR_W'(BASE_ADDR + 8 * pat_data_no[k]);
        cur_record       = pat_record[k];
        reads_seen       = 0;
        answers_seen     = 0;
        sel_action_valid <= 1'b1;
        action           <= action_t'(pat_action[k]);
        formula_valid    <= 1'b1;
        formula          <= formula_t'(pat_formula[k]);
        mode_valid       <= 1'b1;
        mode             <= mode_t'(pat_mode[k]);
        date_valid       <= 1'b1;
        month            <= month_t'(pat_month[k]);
        day              <= day_t'(pat_day[k]);
        @(posedge clk);
        sel_action_valid <= 1'b0;
        formula_valid    <= 1'b0;
        mode_valid       <= 1'b0;
        date_valid       <= 1'b0;
        // today's indices in the order A, B, C, D
        for (int i = 0; i < 4; i++) begin
            index_valid <= 1'b1;
            index       <= INDEX_W'(pat_today[k][i]);
            @(posedge clk);
        end
        index_valid   <= 1'b0;
        data_no_valid <= 1'b1;
        data_no       <= DATA_NO_W'(pat_data_no[k]);
        @(posedge clk);
        data_no_valid <= 1'b0;
    endtask

    task automatic wait_answer(input int k);
        string tag;
        tag = $sformatf("pattern %0d", k);
        do begin
            @(negedge clk);
        end while (!out_valid);
        check_warn(warn_msg, warn_t'(pat_warn[k]), {tag, " warn_msg"});
        check_complete(complete, pat_complete[k][0], {tag, " complete"});
        // give a second pulse the chance to show
        repeat (3) @(posedge clk);
        check_count(answers_seen, 1, {tag, " out_valid pulses"});
        check_count(reads_seen, 1, {tag, " mem_rd pulses"});
    endtask

    // ==============================
    // memory model and monitor
    // ==============================
    initial begin
        int delay;
        forever begin
            @(negedge clk);
            if (rst_n && mem_rd) begin
                delay = draw_delay();
                repeat (delay) @(posedge clk);
                mem_ack  <= 1'b1;
                mem_data <= cur_record;
                @(posedge clk);
                mem_ack  <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                answers_seen++;
            end else begin
                check_warn(warn_msg, no_warn, "warn_msg outside out_valid");
                check_complete(complete, 1'b0, "complete outside out_valid");
            end
            if (mem_rd) begin
                reads_seen++;
                check_addr(mem_addr, exp_addr, "mem_addr");
            end
        end
    end

    // limit scales with the number of operations
    initial begin
        cycles = 0;
        wait (n_pat > 0);
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLES_PER_OP * n_pat + 10) begin
                abort_run("Timeout: the DUT did not finish the operations in time");
            end
        end
    end

    initial begin
        rst_n            = 1'b0;
        sel_action_valid = 1'b0;
        action           = index_check;
        formula_valid    = 1'b0;
        formula          = formula_a;
        mode_valid       = 1'b0;
        mode             = insensitive;
        date_valid       = 1'b0;
        month            = '0;
        day              = '0;
        data_no_valid    = 1'b0;
        data_no          = '0;
        index_valid      = 1'b0;
        index            = '0;
        mem_ack          = 1'b0;
        mem_data         = '0;
        exp_addr         = '0;
        cur_record       = '0;
        reads_seen       = 0;
        answers_seen     = 0;
        n_pat            = 0;
        lfsr             = 16'd33684;
        load_patterns();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < n_pat; k++) begin
            apply_op(k);
            wait_answer(k);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/stock_check_patterns.txt */
# action formula mode month day data_no today_a today_b today_c today_d record(hex) warn complete
# action 0 index_check 1 check_valid_date; mode 0/1/3 insensitive/normal/sensitive; warn 0 none 1 date 3 risk
0 0 0 6 15 0 1000 1000 1000 1000 7ff7ff037ff7ff0a 3 0
0 0 1 6 15 1 1000 1000 1000 1000 3fe3fe033ff3ff0a 0 1
0 0 3 6 15 2 1000 1000 1000 1000 1f420a031ff1ff0a 3 0
0 1 0 6 15 7 1000 1000 1000 1000 3e80c9031f412c0a 0 1
0 1 1 6 15 16 1000 1000 1000 1000 0641f40312c0c80a 3 0
0 1 3 6 15 31 1000 1000 1000 1000 7d076c0370879e0a 3 0
0 2 0 6 15 64 1000 1000 1000 1000 fa07fe03bb89c40a 0 1
0 2 1 6 15 100 1000 1000 1000 1000 3ff7d0035dc44c0a 3 0
0 2 3 6 15 127 1000 1000 1000 1000 2581fe032bc3200a 0 1
0 3 0 6 15 128 1000 1000 1000 1000 7fffff03bb87fe0a 3 0
0 3 1 6 15 170 1000 1000 1000 1000 7ff064037fe0000a 0 1
0 3 3 6 15 200 1000 1000 1000 1000 000000030008000a 3 0
0 4 0 6 15 222 1000 1000 1000 1000 3e93e8035dc3e70a 0 1
0 4 1 6 15 240 1000 1000 1000 1000 3e97d0031f43e80a 3 0
0 4 3 6 15 255 10 20 30 40 0050140301f0280a 3 0
1 0 0 3 9 5 100 100 100 100 064064030640640a 1 0
1 0 0 3 10 6 100 100 100 100 7ff7ff037ff7ff0a 0 1
1 0 0 11 30 9 100 100 100 100 0640640c06406401 1 0
0 0 0 6 15 12 1000 1000 1000 1000 7ff7ff077ff7ff01 1 0

/* stock_check.f */
design/stock_pkg.sv
design/op_fsm.sv
design/calc_counter.sv
design/input_capture.sv
design/record_fetch.sv
design/formula_pipe.sv
design/risk_judge.sv
design/stock_check_top.sv
testbench/tb_stock_check.sv
